// File: include/zorro_consts.svh
// constants only; register indices are address bits 8..2 inside the FF00xxxx window
`ifndef ZORRO_CONSTS_SVH
`define ZORRO_CONSTS_SVH

// upper half-word of the autoconfig space
`define ZORRO_CFG_SPACE 16'hFF00

// base address register, byte offset 44 hex
`define ZORRO_REG_BASE 7'h11

// shut-up register, byte offset 4C hex
`define ZORRO_REG_SHUTUP 7'h13

// nibbles in the config ROM
`define ZORRO_ROM_WORDS 16

// ROM image, nibble 0 in the top four bits
// bytes: type (Z3, memlist), product, flags, reserved,
// manufacturer hi/lo, serial hi (two bytes)
`define ZORRO_ROM_INIT 64'hA042_3000_07DB_0000

// words in the on-card memory
// word index comes from address bits 9..2
`define CARD_RAM_WORDS 256

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# build the Zorro III card testbench with Verilator, run it, judge the run by its log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module zorro_card_tb -f zorro_card.f \
	-Mdir obj_dir -o zorro_card_sim > "$LOG" 2>&1 &&
	./obj_dir/zorro_card_sim >> "$LOG" 2>&1 ||
	{ echo "build or simulation did not complete" >> "$LOG"; cat "$LOG"; exit 1; }

cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
	exit 1
fi
exit 0

// File: src/card_ram.sv
// fixed two-cycle latency; a request still in flight at cycle abort completes anyway
`timescale 1ns/100ps
`include "zorro_consts.svh"

module card_ram (
	input  logic      clk,
	input  logic      reset_i,
	zorro_local_if.mem lbus_i
);
	import zorro_pkg::*;

	bus_word_t mem_q [0:`CARD_RAM_WORDS-1];
	bus_word_t rdata_q;
	logic      pend_q;
	logic      ack_q;

	// request seen, ack follows the cycle after
	// ack blocks a second accept while stb is still high
	always_ff @(posedge clk) begin
		if (reset_i) begin
			pend_q <= 1'b0;
			ack_q  <= 1'b0;
		end else begin
			pend_q <= lbus_i.stb & ~pend_q & ~ack_q;
			ack_q  <= pend_q;
		end
	end

	// array access on the accept cycle
	// read returns the word before any write
	always_ff @(posedge clk) begin
		if (pend_q) begin
			rdata_q <= mem_q[lbus_i.word_addr];
			if (lbus_i.we) begin
				for (int b = 0; b < 4; b++) begin
					if (lbus_i.byte_en[b]) begin
						mem_q[lbus_i.word_addr][8*b +: 8] <= lbus_i.wdata[8*b +: 8];
					end
				end
			end
		end
	end

	// rdata holds after ack until the next access
	assign lbus_i.rdata = rdata_q;
	assign lbus_i.ack   = ack_q;

endmodule

// File: src/zorro_addr_decode.sv
// address is taken one cycle after the sampled /FCS falls, so the master must hold AD that long
`timescale 1ns/100ps
`include "zorro_consts.svh"

module zorro_addr_decode (
	input  logic         clk,
	input  logic         reset_i,
	input  logic         fcs_n_i,
	input  logic [1:0]   fc_i,
	input  logic [7:2]   a_i,
	input  logic [31:8]  ad_i,
	input  logic [7:0]   base_hi_i,
	input  logic         configured_i,
	input  logic         cfg_active_i,
	output logic         card_hit_o,
	output logic         cfg_hit_o,
	output logic [7:0]   word_addr_o,
	output logic [6:0]   reg_index_o
);
	import zorro_pkg::*;

	logic        fcs_n_q;
	logic        fcs_n_qq;
	logic        fcs_fall;
	logic        addr_valid_q;
	logic        fc_ok;
	zorro_addr_u addr_q;

	// resample the full cycle strobe
	// second stage only for edge detect
	always_ff @(posedge clk) begin
		fcs_n_q  <= fcs_n_i;
		fcs_n_qq <= fcs_n_q;
	end

	assign fcs_fall = ~fcs_n_q & fcs_n_qq;

	// latch AD31..8 and the short address at cycle start
	always_ff @(posedge clk) begin
		if (fcs_fall) begin
			addr_q <= {ad_i, a_i, 2'b00};
		end
	end

	// stale address from the previous cycle never hits
	always_ff @(posedge clk) begin
		if (reset_i || fcs_n_q) begin
			addr_valid_q <= 1'b0;
		end else if (fcs_fall) begin
			addr_valid_q <= 1'b1;
		end
	end

	// user data or program space only
	assign fc_ok = fc_i[0] ^ fc_i[1];

	// card window is 32MB, base bits 7..1 against A31..25
	assign card_hit_o = addr_valid_q & fc_ok & configured_i &
		(addr_q.card.window == base_hi_i[7:1]);

	// config space only answered while we hold the chain
	assign cfg_hit_o = addr_valid_q & fc_ok & cfg_active_i &
		(addr_q.cfg.space == `ZORRO_CFG_SPACE);

	// longword index, A9..2
	assign word_addr_o = addr_q.card.offset[7:0];
	assign reg_index_o = addr_q.cfg.reg_index;

endmodule

// File: src/zorro_autoconfig.sv
// iorst_n_i must already be synchronised; on a Zorro II backplane the card stays silent
`timescale 1ns/100ps
`include "zorro_consts.svh"

module zorro_autoconfig (
	input  logic       clk,
	input  logic       reset_i,
	input  logic       iorst_n_i,
	input  logic       sensez3_i,
	input  logic       cfgin_n_i,
	input  logic [6:0] reg_index_i,
	input  logic       cfg_we_i,
	input  logic [7:0] cfg_wbyte_i,
	output logic [3:0] cfg_rdata_o,
	output logic [7:0] base_hi_o,
	output logic       configured_o,
	output logic       cfg_active_o,
	output logic       cfgout_n_o
);

	// nibble i sits at bits 63-4i down
	localparam logic [63:0] ROM_IMAGE = `ZORRO_ROM_INIT;

	logic        cfg_reset;
	logic        configured_q;
	logic        shutup_q;
	logic [7:0]  base_q;
	logic [3:0]  rom_idx;
	logic [3:0]  rom_nib;
	logic        in_rom;

	// bus reset also clears the config state
	assign cfg_reset = reset_i | ~iorst_n_i;

	always_ff @(posedge clk) begin
		if (cfg_reset) begin
			configured_q <= 1'b0;
			shutup_q     <= 1'b0;
		end else if (cfg_we_i) begin
			// D31..24 carries the high base byte
			if (reg_index_i == `ZORRO_REG_BASE) begin
				configured_q <= 1'b1;
			end
			if (reg_index_i == `ZORRO_REG_SHUTUP) begin
				shutup_q <= 1'b1;
			end
		end
	end

	// high byte of the card base address
	always_ff @(posedge clk) begin
		if (cfg_we_i && reg_index_i == `ZORRO_REG_BASE) begin
			base_q <= cfg_wbyte_i;
		end
	end

	// ROM lookup
	assign rom_idx  = reg_index_i[3:0];
	assign rom_nib  = ROM_IMAGE[(`ZORRO_ROM_WORDS - 1 - int'(rom_idx)) * 4 + 3 -: 4];
	assign in_rom   = (reg_index_i < 7'(`ZORRO_ROM_WORDS));

	// first two nibbles read true, the rest inverted
	// past the ROM everything reads zero
	always_comb begin
		if (!in_rom) begin
			cfg_rdata_o = 4'h0;
		end else if (rom_idx < 4'd2) begin
			cfg_rdata_o = rom_nib;
		end else begin
			cfg_rdata_o = ~rom_nib;
		end
	end

	assign base_hi_o    = base_q;
	assign configured_o = configured_q & sensez3_i;

	// respond to config space only while the chain reaches us
	assign cfg_active_o = ~configured_q & ~shutup_q & ~cfgin_n_i & sensez3_i;

	// a Z2 backplane just passes the chain on
	assign cfgout_n_o = sensez3_i ? ~(configured_q | shutup_q) : cfgin_n_i;

endmodule

// File: src/zorro_card.sv
// split in/out/enable pins instead of inout; /BERR and /MTCR are not connected
`timescale 1ns/100ps

module zorro_card (
	input  logic        clk,
	input  logic        reset_i,
	input  logic        iorst_n_i,
	input  logic        sensez3_i,
	input  logic        cfgin_n_i,
	input  logic        read_i,
	input  logic        fcs_n_i,
	input  logic        doe_i,
	input  logic [3:0]  ds_n_i,
	input  logic [1:0]  fc_i,
	input  logic [7:2]  a_i,
	input  logic [31:8] ad_i,
	input  logic [7:0]  sd_i,
	output logic        slave_n_o,
	output logic        dtack_n_o,
	output logic        cfgout_n_o,
	output logic [31:8] ad_o,
	output logic        ad_oe_o,
	output logic [7:0]  sd_o,
	output logic        sd_oe_o
);
	import zorro_pkg::*;

	logic       iorst_n_q;
	logic       core_reset;
	logic       card_hit;
	logic       cfg_hit;
	logic [7:0] word_addr;
	logic [6:0] reg_index;
	logic [7:0] base_hi;
	logic       configured;
	logic       cfg_active;
	logic       cfg_we;
	logic [7:0] cfg_wbyte;
	logic [3:0] cfg_rdata;
	logic       data_oe;
	bus_word_t  rdata;

	zorro_local_if local_bus ();

	// /IORST sampled once, then acts like our own reset
	always_ff @(posedge clk) begin
		iorst_n_q <= iorst_n_i;
	end

	assign core_reset = reset_i | ~iorst_n_q;

	zorro_addr_decode u_decode (
		.clk          (clk),
		.reset_i      (core_reset),
		.fcs_n_i      (fcs_n_i),
		.fc_i         (fc_i),
		.a_i          (a_i),
		.ad_i         (ad_i),
		.base_hi_i    (base_hi),
		.configured_i (configured),
		.cfg_active_i (cfg_active),
		.card_hit_o   (card_hit),
		.cfg_hit_o    (cfg_hit),
		.word_addr_o  (word_addr),
		.reg_index_o  (reg_index)
	);

	zorro_cycle_seq u_seq (
		.clk         (clk),
		.reset_i     (core_reset),
		.fcs_n_i     (fcs_n_i),
		.doe_i       (doe_i),
		.ds_n_i      (ds_n_i),
		.read_i      (read_i),
		.card_hit_i  (card_hit),
		.cfg_hit_i   (cfg_hit),
		.word_addr_i (word_addr),
		.cfg_rdata_i (cfg_rdata),
		.ad_i        (ad_i),
		.sd_i        (sd_i),
		.slave_n_o   (slave_n_o),
		.dtack_n_o   (dtack_n_o),
		.cfg_we_o    (cfg_we),
		.cfg_wbyte_o (cfg_wbyte),
		.rdata_o     (rdata),
		.data_oe_o   (data_oe),
		.lbus_o      (local_bus)
	);

	// gets the raw reset and the sampled /IORST
	zorro_autoconfig u_autoconfig (
		.clk          (clk),
		.reset_i      (reset_i),
		.iorst_n_i    (iorst_n_q),
		.sensez3_i    (sensez3_i),
		.cfgin_n_i    (cfgin_n_i),
		.reg_index_i  (reg_index),
		.cfg_we_i     (cfg_we),
		.cfg_wbyte_i  (cfg_wbyte),
		.cfg_rdata_o  (cfg_rdata),
		.base_hi_o    (base_hi),
		.configured_o (configured),
		.cfg_active_o (cfg_active),
		.cfgout_n_o   (cfgout_n_o)
	);

	card_ram u_ram (
		.clk     (clk),
		.reset_i (core_reset),
		.lbus_i  (local_bus)
	);

	// lane map back onto the pins
	// D23..16 goes out on SD, D15..0 on AD23..8
	assign ad_o    = {rdata[31:24], rdata[15:0]};
	assign sd_o    = rdata[23:16];
	assign ad_oe_o = data_oe;
	assign sd_oe_o = data_oe;

endmodule

// File: src/zorro_cycle_seq.sv
// no bus error or multiple-transfer support; waits forever for DOE and the data strobes
`timescale 1ns/100ps

module zorro_cycle_seq (
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic                 fcs_n_i,
	input  logic                 doe_i,
	input  logic [3:0]           ds_n_i,
	input  logic                 read_i,
	input  logic                 card_hit_i,
	input  logic                 cfg_hit_i,
	input  logic [7:0]           word_addr_i,
	input  logic [3:0]           cfg_rdata_i,
	input  logic [31:8]          ad_i,
	input  logic [7:0]           sd_i,
	output logic                 slave_n_o,
	output logic                 dtack_n_o,
	output logic                 cfg_we_o,
	output logic [7:0]           cfg_wbyte_o,
	output zorro_pkg::bus_word_t rdata_o,
	output logic                 data_oe_o,
	zorro_local_if.host          lbus_o
);
	import zorro_pkg::*;

	logic         fcs_n_q;
	logic         doe_q;
	logic [3:0]   ds_n_q;
	logic         ds_any;
	logic         selected;
	logic         stb_q;
	logic [3:0]   be_q;
	bus_word_t    wdata_q;
	zorro_state_e state_q;

	// one sampling stage on the bus strobes
	always_ff @(posedge clk) begin
		fcs_n_q <= fcs_n_i;
		doe_q   <= doe_i;
		ds_n_q  <= ds_n_i;
	end

	// at least one byte strobe asserted
	assign ds_any = (ds_n_q != 4'hF);

	always_ff @(posedge clk) begin
		if (reset_i || fcs_n_q) begin
			// master ended the cycle
			state_q <= zs_idle;
			stb_q   <= 1'b0;
		end else begin
			case (state_q)
			zs_idle: begin
				if (card_hit_i || cfg_hit_i) begin
					state_q <= zs_match;
				end
			end
			zs_match: begin
				if (doe_q) begin
					state_q <= zs_data;
				end
			end
			zs_data: begin
				if (read_i) begin
					// config nibble is ready at once
					if (cfg_hit_i) begin
						state_q <= zs_dtack;
					end else if (lbus_o.ack) begin
						stb_q   <= 1'b0;
						state_q <= zs_dtack;
					end else begin
						stb_q <= 1'b1;
					end
				end else if (ds_any) begin
					state_q <= zs_write_data;
					// card writes start the memory right away
					stb_q   <= card_hit_i;
				end
			end
			zs_write_data: begin
				if (cfg_hit_i) begin
					state_q <= zs_dtack;
				end else if (lbus_o.ack) begin
					stb_q   <= 1'b0;
					state_q <= zs_dtack;
				end
			end
			zs_dtack: begin
				// hold until /FCS goes away
				state_q <= zs_dtack;
			end
			default: begin
				state_q <= zs_idle;
			end
			endcase
		end
	end

	// write word in lane order: D31..24 on AD31..24, D23..16 on SD, D15..0 on AD23..8
	always_ff @(posedge clk) begin
		if (state_q == zs_data && !read_i && ds_any) begin
			wdata_q <= {ad_i[31:24], sd_i, ad_i[23:8]};
			be_q    <= ~ds_n_q;
		end
	end

	assign lbus_o.stb       = stb_q;
	assign lbus_o.we        = ~read_i;
	assign lbus_o.word_addr = word_addr_i;
	assign lbus_o.wdata     = wdata_q;
	assign lbus_o.byte_en   = be_q;

	// single cycle strobe into the config registers
	assign cfg_we_o    = (state_q == zs_write_data) & cfg_hit_i & ~fcs_n_q;
	assign cfg_wbyte_o = wdata_q[31:24];

	assign selected  = (state_q != zs_idle) & ~fcs_n_q;
	assign slave_n_o = ~selected;
	assign dtack_n_o = ~((state_q == zs_dtack) & ~fcs_n_q);

	// drive lanes only at data time of a read
	assign data_oe_o = selected & doe_q & read_i;

	// config reads carry the nibble in D31..28
	assign rdata_o = cfg_hit_i ? {cfg_rdata_i, 28'h0} : lbus_o.rdata;

endmodule

// File: src/zorro_local_if.sv
// request fields must stay steady from stb until ack; ack is a single-cycle pulse
`timescale 1ns/100ps

interface zorro_local_if;
	import zorro_pkg::*;

	// request side
	logic       stb;
	logic       we;
	logic [7:0] word_addr;
	bus_word_t  wdata;
	// bit 3 strobes D31..24
	logic [3:0] byte_en;

	// response side
	bus_word_t  rdata;
	logic       ack;

	// bus cycle sequencer end
	modport host (
		output stb, we, word_addr, wdata, byte_en,
		input  rdata, ack
	);

	// memory end
	modport mem (
		input  stb, we, word_addr, wdata, byte_en,
		output rdata, ack
	);

endinterface

// File: src/zorro_pkg.sv
// types shared by the card; the address views assume a longword-aligned bus address
package zorro_pkg;

	// cycle sequencer states
	typedef enum logic [2:0] {
		zs_idle,
		zs_match,
		zs_data,
		zs_write_data,
		zs_dtack
	} zorro_state_e;

	// card memory window view
	// window compared against the base register
	typedef struct packed {
		logic [6:0]  window;
		logic [22:0] offset;
		logic [1:0]  zero;
	} zorro_card_addr_t;

	// autoconfig space view
	// pad bits are don't-care in the 64K space
	typedef struct packed {
		logic [15:0] space;
		logic [6:0]  pad;
		logic [6:0]  reg_index;
		logic [1:0]  zero;
	} zorro_cfg_addr_t;

	// one latched bus address, decoded both ways
	typedef union packed {
		zorro_card_addr_t card;
		zorro_cfg_addr_t  cfg;
	} zorro_addr_u;

	// data word in D31..0 order
	typedef logic [31:0] bus_word_t;

endpackage

// File: testbench/tb_clock.sv
// free-running clock from time zero, starts low
`timescale 1ns/100ps

module tb_clock #(
	parameter real PERIOD_NS = 8.0
) (
	output logic clk_o
);

	// half period per toggle
	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2.0) clk_o = ~clk_o;
		end
	end

endmodule

// File: testbench/zorro_card_tb.sv
// single bus master, one cycle per table row; cycles without DTACK end after 20 clocks
`timescale 1ns/100ps
`include "zorro_consts.svh"

module zorro_card_tb;

	localparam int          OP_RESET  = 0;
	localparam int          OP_READ   = 1;
	localparam int          OP_WRITE  = 2;
	localparam logic [7:0]  CARD_BASE = 8'h40;
	localparam logic [31:0] CARD_ADDR = {CARD_BASE, 24'h0};

	logic        clk;
	logic        reset;
	logic        iorst_n;
	logic        sensez3;
	logic        cfgin_n;
	logic        read;
	logic        fcs_n;
	logic        doe;
	logic [3:0]  ds_n;
	logic [1:0]  fc;
	logic [7:2]  a;
	logic [31:8] ad_in;
	logic [7:0]  sd_in;
	logic        slave_n;
	logic        dtack_n;
	logic        cfgout_n;
	logic [31:8] ad_out;
	logic        ad_oe;
	logic [7:0]  sd_out;
	logic        sd_oe;
	int          value_errors;
	int          protocol_errors;
	int          cycles = 0;
	int          cycle_limit = 0;

	// stimulus table with one entry per row
	string       t_name [$];
	int          t_op [$];
	logic [31:0] t_addr [$];
	logic [1:0]  t_fc [$];
	logic [3:0]  t_ds_n [$];
	logic [31:0] t_data [$];
	logic [31:0] t_exp [$];
	logic        t_resp [$];
	logic        t_z3 [$];
	logic        t_cfgin_n [$];
	logic        t_cfgout_n [$];

	// expected card memory contents
	logic [31:0] ram_model [0:`CARD_RAM_WORDS-1];

	tb_clock clock0 (.clk_o(clk));

	zorro_card dut0 (
		.clk        (clk),
		.reset_i    (reset),
		.iorst_n_i  (iorst_n),
		.sensez3_i  (sensez3),
		.cfgin_n_i  (cfgin_n),
		.read_i     (read),
		.fcs_n_i    (fcs_n),
		.doe_i      (doe),
		.ds_n_i     (ds_n),
		.fc_i       (fc),
		.a_i        (a),
		.ad_i       (ad_in),
		.sd_i       (sd_in),
		.slave_n_o  (slave_n),
		.dtack_n_o  (dtack_n),
		.cfgout_n_o (cfgout_n),
		.ad_o       (ad_out),
		.ad_oe_o    (ad_oe),
		.sd_o       (sd_out),
		.sd_oe_o    (sd_oe)
	);

	zorro_checker chk (
		.clk               (clk),
		.reset_i           (reset),
		.fcs_n_i           (fcs_n),
		.slave_n_i         (slave_n),
		.dtack_n_i         (dtack_n),
		.cfgout_n_i        (cfgout_n),
		.ad_i              (ad_out),
		.ad_oe_i           (ad_oe),
		.sd_i              (sd_out),
		.sd_oe_i           (sd_oe),
		.value_errors_o    (value_errors),
		.protocol_errors_o (protocol_errors)
	);

	task automatic add_row(input string name, input int op, input logic [31:0] addr,
		input logic [1:0] fcode, input logic [3:0] dsn, input logic [31:0] data,
		input logic [31:0] exp, input logic resp, input logic z3, input logic cin_n,
		input logic cout_n);
		t_name.push_back(name);
		t_op.push_back(op);
		t_addr.push_back(addr);
		t_fc.push_back(fcode);
		t_ds_n.push_back(dsn);
		t_data.push_back(data);
		t_exp.push_back(exp);
		t_resp.push_back(resp);
		t_z3.push_back(z3);
		t_cfgin_n.push_back(cin_n);
		t_cfgout_n.push_back(cout_n);
	endtask

	// nibbles 0 and 1 true, 2..15 inverted, zero past the ROM
	function automatic logic [31:0] rom_expect(input int idx);
		logic [63:0] img;
		logic [3:0]  nib;
		img = `ZORRO_ROM_INIT;
		if (idx >= `ZORRO_ROM_WORDS) begin
			return 32'h0;
		end
		nib = img[63 - 4 * idx -: 4];
		if (idx >= 2) begin
			nib = ~nib;
		end
		return {nib, 28'h0};
	endfunction

	// merge by strobe with bit 3 as D31..24
	task automatic ram_write_row(input string name, input logic [31:0] addr,
		input logic [3:0] dsn);
		logic [31:0] d;
		logic [7:0]  idx;
		d   = $urandom();
		idx = addr[9:2];
		for (int b = 0; b < 4; b++) begin
			if (!dsn[b]) begin
				ram_model[idx][8*b +: 8] = d[8*b +: 8];
			end
		end
		add_row(name, OP_WRITE, addr, 2'd2, dsn, d, 32'h0, 1'b1, 1'b1, 1'b0, 1'b0);
	endtask

	task automatic ram_read_row(input string name, input logic [31:0] addr);
		add_row(name, OP_READ, addr, 2'd1, 4'hF, 32'h0, ram_model[addr[9:2]], 1'b1, 1'b1,
			1'b0, 1'b0);
	endtask

	task automatic build_table();
		// reset and ROM walk
		add_row("reset z3", OP_RESET, 0, 2'd0, 4'hF, 0, 0, 1'b0, 1'b1, 1'b0, 1'b1);
		for (int i = 0; i < 18; i++) begin
			add_row($sformatf("rom read %0d", i), OP_READ, 32'hFF00_0000 + 32'(i * 4), 2'd1,
				4'hF, 0, rom_expect(i), 1'b1, 1'b1, 1'b0, 1'b1);
		end
		// base write moves the card into its window
		add_row("base write", OP_WRITE, 32'hFF00_0044, 2'd1, 4'b0111, CARD_ADDR, 0, 1'b1,
			1'b1, 1'b0, 1'b0);
		add_row("cfg after base", OP_READ, 32'hFF00_0000, 2'd1, 4'hF, 0, 0, 1'b0, 1'b1,
			1'b0, 1'b0);
		// byte lanes
		ram_write_row("ram full 05", CARD_ADDR + 32'h014, 4'b0000);
		ram_write_row("ram d31 05", CARD_ADDR + 32'h014, 4'b0111);
		ram_write_row("ram d7 05", CARD_ADDR + 32'h014, 4'b1110);
		ram_write_row("ram mid 05", CARD_ADDR + 32'h014, 4'b1001);
		ram_write_row("ram full 3a", CARD_ADDR + 32'h0E8, 4'b0000);
		ram_write_row("ram low 3a", CARD_ADDR + 32'h0E8, 4'b1100);
		ram_write_row("ram high 3a", CARD_ADDR + 32'h0E8, 4'b0011);
		ram_write_row("ram full ff", CARD_ADDR + 32'h3FC, 4'b0000);
		ram_read_row("ram read 05", CARD_ADDR + 32'h014);
		ram_read_row("ram read 3a", CARD_ADDR + 32'h0E8);
		ram_read_row("ram read ff", CARD_ADDR + 32'h3FC);
		// top of the 32MB window folds onto word 5
		ram_read_row("ram alias 05", 32'h41FF_F014);
		// misses
		add_row("wrong window", OP_READ, 32'h5000_0000, 2'd1, 4'hF, 0, 0, 1'b0, 1'b1, 1'b0,
			1'b0);
		add_row("fc 0", OP_READ, CARD_ADDR, 2'd0, 4'hF, 0, 0, 1'b0, 1'b1, 1'b0, 1'b0);
		add_row("fc 3", OP_READ, CARD_ADDR, 2'd3, 4'hF, 0, 0, 1'b0, 1'b1, 1'b0, 1'b0);
		add_row("outside", OP_READ, 32'h1234_5678, 2'd2, 4'hF, 0, 0, 1'b0, 1'b1, 1'b0, 1'b0);
		// configured card on a Zorro II backplane
		add_row("z2 card read", OP_READ, CARD_ADDR + 32'h014, 2'd1, 4'hF, 0, 0, 1'b0, 1'b0,
			1'b1, 1'b1);
		// shut-up
		add_row("reset shutup", OP_RESET, 0, 2'd0, 4'hF, 0, 0, 1'b0, 1'b1, 1'b0, 1'b1);
		add_row("shutup write", OP_WRITE, 32'hFF00_004C, 2'd1, 4'b0111, 0, 0, 1'b1, 1'b1,
			1'b0, 1'b0);
		add_row("silent cfg", OP_READ, 32'hFF00_0000, 2'd1, 4'hF, 0, 0, 1'b0, 1'b1, 1'b0, 1'b0);
		add_row("base after shutup", OP_WRITE, 32'hFF00_0044, 2'd1, 4'b0111, CARD_ADDR, 0,
			1'b0, 1'b1, 1'b0, 1'b0);
		add_row("silent card", OP_READ, CARD_ADDR + 32'h014, 2'd1, 4'hF, 0, 0, 1'b0, 1'b1,
			1'b0, 1'b0);
		// Zorro II backplane passes the chain straight through
		add_row("reset z2", OP_RESET, 0, 2'd0, 4'hF, 0, 0, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row("z2 cfg read", OP_READ, 32'hFF00_0000, 2'd1, 4'hF, 0, 0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row("z2 base write", OP_WRITE, 32'hFF00_0044, 2'd1, 4'b0111, CARD_ADDR, 0, 1'b0,
			1'b0, 1'b0, 1'b0);
	endtask

	// entered and left 1 ns after a rising edge
	task automatic apply_reset(input int r);
		sensez3 = t_z3[r];
		cfgin_n = t_cfgin_n[r];
		reset   = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		// let the checker look at the idle outputs
		@(posedge clk);
		#1;
	endtask

	task automatic bus_cycle(input int r);
		int          waited;
		logic [31:0] d;
		d       = t_data[r];
		sensez3 = t_z3[r];
		cfgin_n = t_cfgin_n[r];
		read    = (t_op[r] == OP_READ);
		fc      = t_fc[r];
		a       = t_addr[r][7:2];
		ad_in   = t_addr[r][31:8];
		@(posedge clk);
		#1;
		fcs_n = 1'b0;
		// address held until the card has latched it
		repeat (3) @(posedge clk);
		#1;
		doe = 1'b1;
		if (t_op[r] == OP_WRITE) begin
			ad_in = {d[31:24], d[15:0]};
			sd_in = d[23:16];
			ds_n  = t_ds_n[r];
		end
		waited = 0;
		@(negedge clk);
		while (dtack_n && waited < 20) begin
			@(negedge clk);
			waited++;
		end
		@(posedge clk);
		#1;
		fcs_n = 1'b1;
		doe   = 1'b0;
		ds_n  = 4'hF;
		read  = 1'b1;
		@(posedge clk);
		#1;
	endtask

	// run limit from the table length
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("run stopped after %0d cycles before the table finished", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin
		reset   = 1'b1;
		iorst_n = 1'b1;
		sensez3 = 1'b1;
		cfgin_n = 1'b0;
		read    = 1'b1;
		fcs_n   = 1'b1;
		doe     = 1'b0;
		ds_n    = 4'hF;
		fc      = 2'd1;
		a       = '0;
		ad_in   = '0;
		sd_in   = '0;
		void'($urandom(47));
		build_table();
		cycle_limit = t_name.size() * 40 + 100;
		for (int r = 0; r < t_name.size(); r++) begin
			chk.set_expect(t_name[r], t_exp[r], t_resp[r],
				(t_op[r] == OP_READ) && t_resp[r], t_cfgout_n[r]);
			if (t_op[r] == OP_RESET) begin
				apply_reset(r);
			end else begin
				bus_cycle(r);
			end
		end
		$display("%0d rows run, %0d value errors, %0d protocol errors", t_name.size(),
			value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: testbench/zorro_checker.sv
// one bus cycle at a time; read data is taken at the first sampled DTACK of a cycle
`timescale 1ns/100ps

module zorro_checker (
	input  logic        clk,
	input  logic        reset_i,
	input  logic        fcs_n_i,
	input  logic        slave_n_i,
	input  logic        dtack_n_i,
	input  logic        cfgout_n_i,
	input  logic [31:8] ad_i,
	input  logic        ad_oe_i,
	input  logic [7:0]  sd_i,
	input  logic        sd_oe_i,
	output int          value_errors_o,
	output int          protocol_errors_o
);

	// expectations of the running row
	string       exp_name;
	logic [31:0] exp_data;
	logic        exp_resp;
	logic        check_data;
	logic        exp_cfgout_n;

	// observations within one cycle
	int          value_errors = 0;
	int          protocol_errors = 0;
	logic        reset_seen = 1'b1;
	logic        in_cycle = 1'b0;
	logic        saw_slave = 1'b0;
	logic        saw_ack = 1'b0;
	logic        lanes_on = 1'b0;
	logic [31:0] got_data = 32'h0;

	assign value_errors_o    = value_errors;
	assign protocol_errors_o = protocol_errors;

	task automatic set_expect(input string name, input logic [31:0] data, input logic resp,
		input logic data_valid, input logic cfgout_n);
		exp_name     = name;
		exp_data     = data;
		exp_resp     = resp;
		check_data   = data_valid;
		exp_cfgout_n = cfgout_n;
	endtask

	task automatic compare_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			value_errors++;
			$display("ERROR %s %s: expected %h, actual %h", exp_name, what, exp, act);
		end
	endtask

	// bus outputs idle, chain as the row expects
	task automatic check_after_reset();
		compare_value("slave_n", 32'd1, 32'(slave_n_i));
		compare_value("dtack_n", 32'd1, 32'(dtack_n_i));
		compare_value("ad_oe", 32'd0, 32'(ad_oe_i));
		compare_value("sd_oe", 32'd0, 32'(sd_oe_i));
		compare_value("cfgout_n", 32'(exp_cfgout_n), 32'(cfgout_n_i));
	endtask

	task automatic check_cycle();
		if (exp_resp) begin
			if (!saw_ack) begin
				protocol_errors++;
				$display("%s: the card never asserted DTACK during the cycle", exp_name);
			end else if (check_data && !lanes_on) begin
				protocol_errors++;
				$display("%s: data lanes were not driven while DTACK was low", exp_name);
			end else if (check_data) begin
				compare_value("data", exp_data, got_data);
			end
		end else if (saw_slave || saw_ack) begin
			protocol_errors++;
			$display("%s: the card answered a cycle it should have ignored", exp_name);
		end
		// chain output settles before the master lets go
		compare_value("cfgout_n", 32'(exp_cfgout_n), 32'(cfgout_n_i));
	endtask

	// falling edge, away from the DUT's register updates
	always @(negedge clk) begin
		if (reset_seen && !reset_i) begin
			check_after_reset();
		end
		reset_seen = reset_i;
		if (!reset_i && !fcs_n_i) begin
			in_cycle = 1'b1;
			if (!slave_n_i) begin
				saw_slave = 1'b1;
			end
			if (!dtack_n_i && !saw_ack) begin
				saw_ack  = 1'b1;
				lanes_on = ad_oe_i & sd_oe_i;
				// D31..24 on AD31..24, D23..16 on SD, D15..0 on AD23..8
				got_data = {ad_i[31:24], sd_i, ad_i[23:8]};
			end
		end else if (in_cycle) begin
			// master released /FCS
			check_cycle();
			in_cycle  = 1'b0;
			saw_slave = 1'b0;
			saw_ack   = 1'b0;
			lanes_on  = 1'b0;
		end
	end

endmodule

// File: zorro_card.f
+incdir+include
src/zorro_pkg.sv
src/zorro_local_if.sv
src/zorro_addr_decode.sv
src/zorro_autoconfig.sv
src/zorro_cycle_seq.sv
src/card_ram.sv
src/zorro_card.sv
testbench/tb_clock.sv
testbench/zorro_checker.sv
testbench/zorro_card_tb.sv
